// ==== eth_readout_settings.svh ====
`ifndef ETH_READOUT_SETTINGS_SVH
`define ETH_READOUT_SETTINGS_SVH

// FIFO depths
`define EVT_FIFO_DEPTH 128
`define L1A_FIFO_DEPTH 16

`define EVT_AFULL_LEVEL 96 // Almost full at or above
`define EVT_AMT_LEVEL 8    // Almost empty below

// Fixed trailer words
`define FRM_TRL_ID 16'h700C
`define FRM_TRL_END 16'h7FFF

// Leading samples that carry the trigger phase
`define PHASE_SAMPLES 6

`endif

// ==== eth_readout_pkg.sv ====
`default_nettype none

package eth_readout_pkg;

	// Event FIFO word
	typedef struct packed {
		logic movlp;       // Multiple overlap
		logic ovlp;
		logic [3:0] ocnt;  // Overlap count
		logic [11:0] data; // ADC sample
	} evt_word_t;

	// Trigger record
	typedef struct packed {
		logic phase;
		logic [11:0] mcnt; // Match count
		logic [23:0] num;  // Trigger number
	} l1a_rec_t;

	typedef enum logic [2:0] {
		SLOT_L1A_HI,
		SLOT_L1A_LO,
		SLOT_SAMPLE,
		SLOT_CRC,
		SLOT_TRL_ID,
		SLOT_STATUS,
		SLOT_TRL_END
	} slot_t;

	// One word slot of a frame
	typedef struct packed {
		slot_t slot;
		logic [6:0] smp;   // Sample index
		logic crc_clr;     // Frame start
		logic valid;
	} frame_ctl_t;

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = 16,
	parameter int AFULL_LEVEL = 12,
	parameter int AMT_LEVEL = 4
) (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire push,
	input wire item_t din,
	input wire pop,
	output item_t dout,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic afull,
	output logic amt
);

	localparam int AW = $clog2(DEPTH);

	item_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push && !full;  // Dropped when full
	assign do_pop = pop && !empty;

	always_ff @(posedge RCLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr]; // Show-ahead

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == 0);
	assign full = (count == DEPTH);
	assign afull = (count >= AFULL_LEVEL);
	assign amt = (count < AMT_LEVEL);

endmodule

`default_nettype wire

// ==== frame_sequencer.sv ====
`default_nettype none

module frame_sequencer import eth_readout_pkg::*; (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire txack,
	input wire [6:0] samp_max,
	input wire [7:0] evt_count,
	input wire l1a_empty,
	input wire [4:0] l1a_count,
	input wire l1a_rec_t l1a_rec,
	output logic evt_pop,
	output logic l1a_pop,
	output frame_ctl_t ctl,
	output logic ce,
	output l1a_rec_t rec,
	output logic [4:0] occupancy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_SAMPLE,
		ST_TRAILER
	} state_t;

	state_t state;
	logic [1:0] slot_cnt;
	logic [6:0] smp_cnt;
	logic start;

	assign ce = txack; // Whole path stalls with TXACK

	// A trigger is waiting and all its samples are buffered
	assign start = !l1a_empty && (evt_count >= {1'b0, samp_max} + 8'd1);

	assign l1a_pop = ce && (state == ST_IDLE) && start;
	assign evt_pop = ce && ctl.valid && (ctl.slot == SLOT_SAMPLE);

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= ST_IDLE;
			slot_cnt <= '0;
			smp_cnt <= '0;
			ctl <= '0;
		end else if (ce) begin
			ctl.valid <= 1'b1;
			ctl.crc_clr <= 1'b0;
			ctl.smp <= smp_cnt;
			case (state)
				ST_IDLE: begin
					ctl.slot <= SLOT_L1A_HI;
					ctl.valid <= start;
					ctl.crc_clr <= start;
					if (start)
						state <= ST_HEADER;
				end
				ST_HEADER: begin
					ctl.slot <= SLOT_L1A_LO;
					smp_cnt <= '0;
					state <= ST_SAMPLE;
				end
				ST_SAMPLE: begin
					ctl.slot <= SLOT_SAMPLE;
					smp_cnt <= smp_cnt + 7'd1;
					if (smp_cnt == samp_max) begin
						slot_cnt <= '0;
						state <= ST_TRAILER;
					end
				end
				ST_TRAILER: begin
					case (slot_cnt)
						2'd0: ctl.slot <= SLOT_CRC;
						2'd1: ctl.slot <= SLOT_TRL_ID;
						2'd2: ctl.slot <= SLOT_STATUS;
						default: ctl.slot <= SLOT_TRL_END;
					endcase
					slot_cnt <= slot_cnt + 2'd1;
					if (slot_cnt == 2'd3)
						state <= ST_IDLE; // Next frame may follow at once
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Record and remaining trigger occupancy for the frame being issued
	always_ff @(posedge RCLK) begin
		if (l1a_pop) begin
			rec <= l1a_rec;
			occupancy <= l1a_count - 5'd1;
		end
	end

endmodule

`default_nettype wire

// ==== frame_builder.sv ====
`default_nettype none
`include "eth_readout_settings.svh"

module frame_builder import eth_readout_pkg::*; (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire ce,
	input wire frame_ctl_t ctl,
	input wire l1a_rec_t rec,
	input wire [4:0] occupancy,
	input wire evt_word_t evt,
	input wire warn,
	output logic [15:0] txd,
	output logic txd_vld
);

	frame_ctl_t ctl1;
	logic [15:0] word1;
	logic [15:0] stat1;
	logic [14:0] crc;
	logic [15:0] frame2;
	logic vld2;
	logic phase_flag;

	// Parallel CRC-15 over 13 data bits
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i < 13; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

	assign phase_flag = rec.phase && (ctl.smp < 7'(`PHASE_SAMPLES));

	// Stage 1, header and sample words
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			ctl1 <= '0;
		else if (ce)
			ctl1 <= ctl;
	end

	always_ff @(posedge RCLK) begin
		if (ce) begin
			case (ctl.slot)
				SLOT_L1A_HI: word1 <= {4'h0, rec.num[23:12]};
				SLOT_L1A_LO: word1 <= {4'h0, rec.num[11:0]};
				default: word1 <= {1'b0, 1'b1, phase_flag, 1'b0, evt.data}; // Overlap always set
			endcase
			stat1 <= {4'h7, rec.num[5:0], occupancy, warn};
		end
	end

	// Stage 2, CRC and word select
	always_ff @(posedge RCLK) begin
		if (ce) begin
			if (ctl1.crc_clr)
				crc <= '0;
			else if (ctl1.valid && ctl1.slot == SLOT_SAMPLE)
				crc <= crc15_d13(word1[12:0], crc); // Zero then the 12 data bits
			case (ctl1.slot)
				SLOT_CRC: frame2 <= {1'b0, crc};
				SLOT_TRL_ID: frame2 <= `FRM_TRL_ID;
				SLOT_STATUS: frame2 <= stat1;
				SLOT_TRL_END: frame2 <= `FRM_TRL_END;
				default: frame2 <= word1;
			endcase
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			vld2 <= 1'b0;
			txd_vld <= 1'b0;
		end else if (ce) begin
			vld2 <= ctl1.valid;
			txd_vld <= vld2;
		end
	end

	// Stage 3, output register
	always_ff @(posedge RCLK) begin
		if (ce)
			txd <= frame2;
	end

endmodule

`default_nettype wire

// ==== eth_fifo.sv ====
`default_nettype none
`include "eth_readout_settings.svh"

module eth_fifo import eth_readout_pkg::*; (
	input wire RCLK,
	input wire RST_RESYNC,
	input wire [6:0] SAMP_MAX,
	input wire evt_word_t WDATA,
	input wire WREN,
	input wire l1a_rec_t L1A_EVT_DATA,
	input wire L1A_WRT_EN,
	input wire WARN,
	input wire TXACK,
	output logic EVT_BUF_AMT,
	output logic EVT_BUF_AFL,
	output logic [15:0] TXD,
	output logic TXD_VLD
);

	evt_word_t evt_dout;
	l1a_rec_t l1a_dout;
	l1a_rec_t rec;
	frame_ctl_t ctl;
	logic [7:0] evt_count;
	logic [4:0] l1a_count;
	logic [4:0] occupancy;
	logic l1a_empty;
	logic evt_pop;
	logic l1a_pop;
	logic ce;

	sync_fifo #(
		.item_t(evt_word_t),
		.DEPTH(`EVT_FIFO_DEPTH),
		.AFULL_LEVEL(`EVT_AFULL_LEVEL),
		.AMT_LEVEL(`EVT_AMT_LEVEL)
	) evt_fifo_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.push(WREN),
		.din(WDATA),
		.pop(evt_pop),
		.dout(evt_dout),
		.empty(),
		.full(),
		.count(evt_count),
		.afull(EVT_BUF_AFL),
		.amt(EVT_BUF_AMT)
	);

	// Trigger FIFO flags beyond empty are not used
	sync_fifo #(
		.item_t(l1a_rec_t),
		.DEPTH(`L1A_FIFO_DEPTH),
		.AFULL_LEVEL(`L1A_FIFO_DEPTH - 1),
		.AMT_LEVEL(1)
	) l1a_fifo_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.push(L1A_WRT_EN),
		.din(L1A_EVT_DATA),
		.pop(l1a_pop),
		.dout(l1a_dout),
		.empty(l1a_empty),
		.full(),
		.count(l1a_count),
		.afull(),
		.amt()
	);

	frame_sequencer frame_sequencer_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.txack(TXACK),
		.samp_max(SAMP_MAX),
		.evt_count(evt_count),
		.l1a_empty(l1a_empty),
		.l1a_count(l1a_count),
		.l1a_rec(l1a_dout),
		.evt_pop(evt_pop),
		.l1a_pop(l1a_pop),
		.ctl(ctl),
		.ce(ce),
		.rec(rec),
		.occupancy(occupancy)
	);

	frame_builder frame_builder_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.ce(ce),
		.ctl(ctl),
		.rec(rec),
		.occupancy(occupancy),
		.evt(evt_dout),
		.warn(WARN),
		.txd(TXD),
		.txd_vld(TXD_VLD)
	);

endmodule

`default_nettype wire

// ==== tb_eth_fifo.sv ====
`default_nettype none
`include "eth_readout_settings.svh"

module tb_eth_fifo import eth_readout_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'hfec9_8fda;
	localparam int TOTAL_WORDS = 8 * 22 + 6 * 22 + 25 * 10;
	localparam int WATCHDOG_NS = 4 * TOTAL_WORDS * 20 + 20000;

	logic RCLK;
	logic RST_RESYNC;
	logic [6:0] SAMP_MAX;
	evt_word_t WDATA;
	logic WREN;
	l1a_rec_t L1A_EVT_DATA;
	logic L1A_WRT_EN;
	logic WARN;
	logic TXACK;
	logic EVT_BUF_AMT;
	logic EVT_BUF_AFL;
	logic [15:0] TXD;
	logic TXD_VLD;

	logic [31:0] rng;
	logic [31:0] ack_rng;
	logic ack_random;
	logic advanced;

	// Model state: FIFO contents as written, and words still to come
	evt_word_t evt_mq[$];
	l1a_rec_t l1a_mq[$];
	logic [15:0] exp_q[$];

	eth_fifo dut_i (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.SAMP_MAX(SAMP_MAX),
		.WDATA(WDATA),
		.WREN(WREN),
		.L1A_EVT_DATA(L1A_EVT_DATA),
		.L1A_WRT_EN(L1A_WRT_EN),
		.WARN(WARN),
		.TXACK(TXACK),
		.EVT_BUF_AMT(EVT_BUF_AMT),
		.EVT_BUF_AFL(EVT_BUF_AFL),
		.TXD(TXD),
		.TXD_VLD(TXD_VLD)
	);

	initial begin
		RCLK = 1'b0;
		forever #10 RCLK = ~RCLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// CRC-15 step written as rotated register terms plus data terms
	function automatic logic [14:0] crc15_next(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] rot2;
		logic [14:0] rot1;
		rot2 = {c[1:0], c[14:2]};
		rot1 = {c[0], c[14:1]};
		return rot2 ^ (rot1 & 15'h3FFE) ^ {2'b00, d} ^ {1'b0, d, 1'b0};
	endfunction

	task automatic report_problem(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input logic [15:0] want,
			input logic [15:0] got);
		$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic step_cycle();
		@(posedge RCLK);
		#2;
	endtask

	task automatic write_events(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			WDATA = evt_word_t'(rng[17:0]);
			WREN = 1'b1;
			evt_mq.push_back(WDATA);
			step_cycle();
		end
		WREN = 1'b0;
	endtask

	task automatic write_triggers(input int n);
		int i;
		logic [31:0] r1;
		for (i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			r1 = rng;
			rng = xorshift32(rng);
			L1A_EVT_DATA = l1a_rec_t'({r1[0], r1[12:1], rng[23:0]});
			L1A_WRT_EN = 1'b1;
			l1a_mq.push_back(L1A_EVT_DATA);
			step_cycle();
		end
		L1A_WRT_EN = 1'b0;
	endtask

	task automatic wait_drained();
		while (l1a_mq.size() != 0 || exp_q.size() != 0)
			step_cycle();
		repeat (10) step_cycle(); // Nothing more may show up
	endtask

	// Expected words of the next frame, from the oldest trigger and events
	task automatic build_frame();
		l1a_rec_t r;
		evt_word_t e;
		logic [14:0] crc;
		logic [4:0] occ;
		logic ph;
		int n;
		int i;
		r = l1a_mq.pop_front();
		occ = 5'(l1a_mq.size());
		n = int'(SAMP_MAX) + 1;
		if (evt_mq.size() < n)
			report_problem("frame sent before enough event words were written");
		crc = '0;
		exp_q.push_back({4'h0, r.num[23:12]});
		exp_q.push_back({4'h0, r.num[11:0]});
		for (i = 0; i < n; i++) begin
			e = evt_mq.pop_front();
			ph = r.phase && (i < `PHASE_SAMPLES);
			exp_q.push_back({2'b01, ph, 1'b0, e.data});
			crc = crc15_next({1'b0, e.data}, crc);
		end
		exp_q.push_back({1'b0, crc});
		exp_q.push_back(`FRM_TRL_ID);
		exp_q.push_back({4'h7, r.num[5:0], occ, WARN});
		exp_q.push_back(`FRM_TRL_END);
	endtask

	task automatic check_word();
		logic [15:0] want;
		if (exp_q.size() == 0) begin
			if (l1a_mq.size() == 0)
				report_problem("TXD_VLD high with no trigger pending");
			build_frame();
		end
		want = exp_q.pop_front();
		assert (TXD === want) else report_value("TXD", want, TXD);
	endtask

	// A new word is on TXD only after an edge with TXACK high
	always @(posedge RCLK)
		advanced <= TXACK && !RST_RESYNC;

	always @(negedge RCLK) begin
		if (!RST_RESYNC && advanced && TXD_VLD)
			check_word();
	end

	always @(posedge RCLK) begin
		#2;
		if (ack_random) begin
			ack_rng = xorshift32(ack_rng);
			TXACK = (ack_rng[1:0] != 2'b00); // Low about one cycle in four
		end else begin
			TXACK = 1'b1;
		end
	end

	hold_while_stalled: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		!TXACK |=> $stable(TXD) && $stable(TXD_VLD))
		else report_problem("TXD or TXD_VLD changed while TXACK was low");

	initial begin
		#(WATCHDOG_NS);
		report_problem("watchdog expired before all frames were sent");
	end

	initial begin
		RST_RESYNC = 1'b1;
		SAMP_MAX = 7'd15;
		WDATA = '0;
		WREN = 1'b0;
		L1A_EVT_DATA = '0;
		L1A_WRT_EN = 1'b0;
		WARN = 1'b0;
		TXACK = 1'b1;
		rng = SEED;
		ack_rng = ~SEED;
		ack_random = 1'b0;
		repeat (16) @(posedge RCLK);
		#2;
		RST_RESYNC = 1'b0;
		assert (TXD_VLD === 1'b0) else report_value("TXD_VLD", 16'd0, 16'(TXD_VLD));
		assert (EVT_BUF_AMT === 1'b1) else report_value("EVT_BUF_AMT", 16'd1, 16'(EVT_BUF_AMT));
		assert (EVT_BUF_AFL === 1'b0) else report_value("EVT_BUF_AFL", 16'd0, 16'(EVT_BUF_AFL));

		// A whole frame of events but no trigger
		write_events(16);
		repeat (20) step_cycle();

		// Eight frames, triggers written ahead of their data
		SAMP_MAX = 7'd127; // Hold off frames until all triggers are in
		write_triggers(8);
		SAMP_MAX = 7'd15;
		write_events(8 * 16 - 16);
		wait_drained();

		ack_random = 1'b1;
		write_triggers(6);
		write_events(6 * 16);
		wait_drained();
		ack_random = 1'b0;
		repeat (4) step_cycle();

		// Fill past the watermark while frames cannot start yet
		SAMP_MAX = 7'd127;
		write_events(100);
		assert (EVT_BUF_AFL === 1'b1) else report_value("EVT_BUF_AFL", 16'd1, 16'(EVT_BUF_AFL));
		WARN = 1'b1;
		write_triggers(16);
		SAMP_MAX = 7'd3;
		wait_drained();
		assert (EVT_BUF_AFL === 1'b0) else report_value("EVT_BUF_AFL", 16'd0, 16'(EVT_BUF_AFL));
		assert (EVT_BUF_AMT === 1'b0) else report_value("EVT_BUF_AMT", 16'd0, 16'(EVT_BUF_AMT));
		SAMP_MAX = 7'd127;
		write_triggers(9);
		SAMP_MAX = 7'd3;
		wait_drained();
		assert (EVT_BUF_AMT === 1'b1) else report_value("EVT_BUF_AMT", 16'd1, 16'(EVT_BUF_AMT));
		assert (EVT_BUF_AFL === 1'b0) else report_value("EVT_BUF_AFL", 16'd0, 16'(EVT_BUF_AFL));

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
eth_readout_pkg.sv
sync_fifo.sv
frame_sequencer.sv
frame_builder.sv
eth_fifo.sv
tb_eth_fifo.sv

// ==== Bender.yml ====
package:
  name: eth_readout

sources:
  - include_dirs:
      - .
    files:
      - eth_readout_pkg.sv
      - sync_fifo.sv
      - frame_sequencer.sv
      - frame_builder.sv
      - eth_fifo.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_eth_fifo.sv
